// File: dv/cpu6_stim.txt
# P <word index, hex> <instruction word, hex>   program memory
# E <byte address, hex> <data, hex>             expected stores, in order
P 00 20000093  addi x1, x0, 0x200
P 01 00700113  addi x2, x0, 7
P 02 ffd00193  addi x3, x0, -3
P 03 00310233  add  x4, x2, x3
P 04 0040a023  sw   x4, 0(x1)
P 05 40310233  sub  x4, x2, x3
P 06 0040a223  sw   x4, 4(x1)
P 07 00317233  and  x4, x2, x3
P 08 0040a423  sw   x4, 8(x1)
P 09 00316233  or   x4, x2, x3
P 0a 0040a623  sw   x4, 12(x1)
P 0b 00314233  xor  x4, x2, x3
P 0c 0040a823  sw   x4, 16(x1)
P 0d 0021a233  slt  x4, x3, x2
P 0e 0040aa23  sw   x4, 20(x1)
P 0f 123452b7  lui  x5, 0x12345
P 10 0050ac23  sw   x5, 24(x1)
P 11 0000a303  lw   x6, 0(x1)
P 12 0060ae23  sw   x6, 28(x1)
P 13 00310463  beq  x2, x3, +8    not taken
P 14 0220a023  sw   x2, 32(x1)
P 15 00311463  bne  x2, x3, +8    taken
P 16 0230a223  sw   x3, 36(x1)    skipped
P 17 00210463  beq  x2, x2, +8    taken
P 18 0230a423  sw   x3, 40(x1)    skipped
P 19 00211463  bne  x2, x2, +8    not taken
P 1a 0220a623  sw   x2, 44(x1)
P 1b 008003ef  jal  x7, +8
P 1c 0230a823  sw   x3, 48(x1)    skipped
P 1d 0270aa23  sw   x7, 52(x1)
P 1e 10000413  addi x8, x0, 0x100
P 1f 30541073  csrrw x0, mtvec, x8
P 20 00000000  illegal word
P 21 0220ac23  sw   x2, 56(x1)    after mret
P 22 0000006f  jal  x0, 0
P 40 341024f3  csrrs x9, mepc, x0   trap handler
P 41 0290ae23  sw   x9, 60(x1)
P 42 00448493  addi x9, x9, 4
P 43 34149073  csrrw x0, mepc, x9
P 44 30200073  mret
E 00000200 00000004
E 00000204 0000000a
E 00000208 00000005
E 0000020c ffffffff
E 00000210 fffffffa
E 00000214 00000001
E 00000218 12345000
E 0000021c 00000004
E 00000220 00000007
E 0000022c 00000007
E 00000234 00000070
E 0000023c 00000080
E 00000238 00000007

// File: all.f
verilog/cpu6_pkg.sv
verilog/cpu6_regfile.sv
verilog/cpu6_csr.sv
verilog/cpu6_controller.sv
verilog/cpu6_excp.sv
verilog/cpu6_pipelinereg_idex.sv
verilog/cpu6_datapath.sv
verilog/cpu6_core.sv
dv/cpu6_tb.sv

// File: Bender.yml
package:
  name: cpu6

sources:
  - verilog/cpu6_pkg.sv
  - verilog/cpu6_regfile.sv
  - verilog/cpu6_csr.sv
  - verilog/cpu6_controller.sv
  - verilog/cpu6_excp.sv
  - verilog/cpu6_pipelinereg_idex.sv
  - verilog/cpu6_datapath.sv
  - verilog/cpu6_core.sv
  - target: simulation
    files:
      - dv/cpu6_tb.sv

// File: dv/cpu6_tb.sv
module cpu6_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MemWords = 256;
   localparam int MaxExp   = 64;
   localparam StimFile     = "dv/cpu6_stim.txt";

   logic           clk;
   logic           reset;
   logic           memwriteM;
   cpu6_pkg::xlenT pcF, instr, dataaddr, writedata, readdata;

   cpu6_pkg::xlenT imem [MemWords];
   cpu6_pkg::xlenT dmem [MemWords];
   cpu6_pkg::xlenT expAddr [MaxExp];
   cpu6_pkg::xlenT expData [MaxExp];

   int progLen, expCount, storeIdx;
   int passCount, failCount;
   int cycleCount, cycleLimit;
   bit stimOk;

   cpu6_core #(
      .XLEN (cpu6_pkg::Xlen)
   ) u_dut (
      .clk, .reset, .pcF, .instr, .memwriteM, .dataaddr, .writedata, .readdata
   );

   // both memories answer in the same cycle
   assign instr    = imem[pcF[9:2]];
   assign readdata = dmem[dataaddr[9:2]];

   always #50 clk = ~clk;

   always @(posedge clk) begin
      if (memwriteM === 1'b1) begin
         dmem[dataaddr[9:2]] <= writedata;
      end
   end

   task automatic checkWord(input string name, input cpu6_pkg::xlenT expected,
                            input cpu6_pkg::xlenT actual);
      if (actual === expected) begin
         passCount++;
      end else begin
         failCount++;
         $display("FAILED %s: expected %h, got %h", name, expected, actual);
      end
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      if (actual === expected) begin
         passCount++;
      end else begin
         failCount++;
         $display("FAILED %s: expected %h, got %h", name, expected, actual);
      end
   endtask

   // tagged lines, anything after the two fields is a remark
   task automatic loadStim(output bit ok);
      int                  fd;
      int                  code;
      logic [7:0]          tag;
      logic [8*128-1:0]    rest;
      cpu6_pkg::xlenT      first, second;
      ok       = 1'b0;
      progLen  = 0;
      expCount = 0;
      fd = $fopen(StimFile, "r");
      if (fd == 0) begin
         $display("could not open the stimulus file %s", StimFile);
      end else begin
         ok   = 1'b1;
         code = $fscanf(fd, " %c", tag);
         while (code == 1) begin
            if ((tag == "P") || (tag == "E")) begin
               code = $fscanf(fd, "%h %h", first, second);
               if (code != 2) begin
                  $display("a %s line in the stimulus file is malformed", tag);
                  ok = 1'b0;
               end else if (tag == "P") begin
                  if (first < MemWords) begin
                     imem[first] = second;
                     progLen++;
                  end else begin
                     $display("program word index %h lies outside the memory", first);
                     ok = 1'b0;
                  end
               end else if (expCount < MaxExp) begin
                  expAddr[expCount] = first;
                  expData[expCount] = second;
                  expCount++;
               end else begin
                  $display("the stimulus file holds too many expected stores");
                  ok = 1'b0;
               end
            end else if (tag != "#") begin
               $display("unknown line tag %s in the stimulus file", tag);
               ok = 1'b0;
            end
            code = $fgets(rest, fd);
            code = $fscanf(fd, " %c", tag);
         end
         $fclose(fd);
      end
   endtask

   // one store on the bus against the next entry of the list
   task automatic matchStore();
      int failsBefore;
      failsBefore = failCount;
      if (storeIdx >= expCount) begin
         failCount++;
         $display("a store to %h with data %h was not expected", dataaddr, writedata);
      end else begin
         checkWord("dataaddr", expAddr[storeIdx], dataaddr);
         checkWord("writedata", expData[storeIdx], writedata);
         $display("test store %0d at %h: %s", storeIdx, expAddr[storeIdx],
                  (failCount == failsBefore) ? "ok" : "failed");
      end
      storeIdx++;
   endtask

   always @(posedge clk) begin
      if (!reset && (memwriteM === 1'b1)) begin
         matchStore();
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if ((cycleLimit > 0) && (cycleCount >= cycleLimit)) begin
         $display("timeout after %0d cycles, the program did not reach its final store",
                  cycleCount);
         $display("checks passed %0d, failed %0d", passCount, failCount);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial begin
      int failsBefore;
      clk        = 1'b0;
      reset      = 1'b1;
      storeIdx   = 0;
      passCount  = 0;
      failCount  = 0;
      cycleCount = 0;
      cycleLimit = 0;
      // unused words are addi x0, x0 with their own byte address as immediate
      for (int i = 0; i < MemWords; i++) begin
         imem[i] = {12'(i * 4), 20'h00013};
         dmem[i] = 32'hd5a0_0000 ^ cpu6_pkg::xlenT'(i * 4);
      end
      loadStim(stimOk);
      if (!stimOk) begin
         $display("the stimulus file could not be used");
         $display("*** TEST FAILED ***");
         $finish;
      end else begin
         cycleLimit = 4 * progLen + 20 * expCount + 100;
         failsBefore = failCount;
         repeat (4) @(posedge clk);
         checkWord("pcF", cpu6_pkg::ResetPc, pcF);
         checkFlag("memwriteM", 1'b0, memwriteM);
         @(posedge clk);
         #1 reset = 1'b0;
         @(posedge clk);
         checkWord("pcF", cpu6_pkg::ResetPc, pcF);
         checkFlag("memwriteM", 1'b0, memwriteM);
         $display("test reset state: %s", (failCount == failsBefore) ? "ok" : "failed");
         wait (storeIdx >= expCount);
         // a few more cycles to catch a stray store behind the last one
         repeat (10) @(posedge clk);
         $display("checks passed %0d, failed %0d", passCount, failCount);
         if (failCount == 0) begin
            $display("*** TEST PASSED ***");
         end else begin
            $display("*** TEST FAILED ***");
         end
         $finish;
      end
   end

endmodule

// File: verilog/cpu6_core.sv
module cpu6_core #(
   parameter int XLEN = cpu6_pkg::Xlen
) (
   input  logic           clk,
   input  logic           reset,
   output cpu6_pkg::xlenT pcF,
   input  cpu6_pkg::xlenT instr,
   output logic           memwriteM,
   output cpu6_pkg::xlenT dataaddr,
   output cpu6_pkg::xlenT writedata,
   input  cpu6_pkg::xlenT readdata
);

   // decoded in F/D
   logic memtoreg, memwrite, alusrc, regwrite, jump, mret, csr, csrRs1Uimm;
   logic illinstr;
   cpu6_pkg::branchTypeT branchtype;
   cpu6_pkg::aluCtrlT    alucontrol;
   cpu6_pkg::immTypeT    immtype;
   cpu6_pkg::csrWscT     csrWsc;

   // registered for E
   logic memtoregE, memwriteE, alusrcE, regwriteE, jumpE, csrE, csrRs1UimmE;
   cpu6_pkg::branchTypeT branchtypeE;
   cpu6_pkg::aluCtrlT    alucontrolE;
   cpu6_pkg::immTypeT    immtypeE;
   cpu6_pkg::csrWscT     csrWscE;
   cpu6_pkg::xlenT       pcE, instrE;

   cpu6_pkg::xlenT pcPlus4F, pcNextF, excpPc;
   cpu6_pkg::xlenT pcnextE, csrMtvec, csrMepc;
   cpu6_pkg::xlenT excpFlushPc, excpMepc;
   logic           pcsrcE, flashE, holdF;
   logic           excpFlushPcEna, excpMepcEna;

   // pcF moves on the falling edge so the instruction memory has it settled by the
   // next rising edge; excpPc trails it by one fetch for the trap logic
   always_ff @(negedge clk) begin
      if (reset) begin
         pcF    <= cpu6_pkg::ResetPc;
         excpPc <= cpu6_pkg::ResetPc;
         holdF  <= 1'b1;
      end else begin
         pcF    <= pcNextF;
         excpPc <= pcF;
         holdF  <= pcsrcE;
      end
   end

   assign pcPlus4F = pcF + XLEN'(4);

   // holdF keeps pcF one more fetch after reset and after a taken branch,
   // since the word first fetched there falls into the flushed slot
   assign pcNextF = mret           ? csrMepc     :
                    excpFlushPcEna ? excpFlushPc :
                    pcsrcE         ? pcnextE     :
                    holdF          ? pcF         :
                    pcPlus4F;

   assign flashE = pcsrcE;

   cpu6_controller u_controller (
      .op     (instr[cpu6_pkg::OpcodeHigh:cpu6_pkg::OpcodeLow]),
      .funct3 (instr[cpu6_pkg::Funct3High:cpu6_pkg::Funct3Low]),
      .funct7 (instr[cpu6_pkg::Funct7High:cpu6_pkg::Funct7Low]),
      .memtoreg, .memwrite, .alusrc, .regwrite, .jump, .mret,
      .csr, .csrRs1Uimm, .branchtype, .alucontrol, .immtype, .csrWsc,
      .illinstr
   );

   cpu6_excp u_excp (
      .clk, .reset, .excpPc,
      .excpIllinstr (illinstr),
      .csrMtvec,
      .excpFlushPcEna, .excpFlushPc, .excpMepcEna, .excpMepc
   );

   // an illegal word squashes itself on its way into E
   cpu6_pipelinereg_idex u_idex (
      .clk, .reset,
      .flash (flashE || excpFlushPcEna),
      .memtoreg, .memwrite, .alusrc, .regwrite, .jump, .csr, .csrRs1Uimm,
      .branchtype, .alucontrol, .immtype, .csrWsc,
      .pc    (pcF),
      .instr,
      .memtoregE, .memwriteE, .alusrcE, .regwriteE, .jumpE, .csrE, .csrRs1UimmE,
      .branchtypeE, .alucontrolE, .immtypeE, .csrWscE, .pcE, .instrE
   );

   cpu6_datapath #(
      .XLEN (XLEN)
   ) u_datapath (
      .clk, .reset,
      .memtoregE, .memwriteE, .alusrcE, .regwriteE, .jumpE, .csrE, .csrRs1UimmE,
      .branchtypeE, .alucontrolE, .immtypeE, .csrWscE, .pcE, .instrE,
      .excpMepc, .excpMepcEna,
      .readdataM  (readdata),
      .pcnextE, .pcsrcE, .csrMtvec, .csrMepc,
      .dataaddrM  (dataaddr),
      .writedataM (writedata),
      .memwriteM
   );

endmodule

// File: verilog/cpu6_datapath.sv
module cpu6_datapath #(
   parameter int XLEN = cpu6_pkg::Xlen
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 memtoregE,
   input  logic                 memwriteE,
   input  logic                 alusrcE,
   input  logic                 regwriteE,
   input  logic                 jumpE,
   input  logic                 csrE,
   input  logic                 csrRs1UimmE,
   input  cpu6_pkg::branchTypeT branchtypeE,
   input  cpu6_pkg::aluCtrlT    alucontrolE,
   input  cpu6_pkg::immTypeT    immtypeE,
   input  cpu6_pkg::csrWscT     csrWscE,
   input  cpu6_pkg::xlenT       pcE,
   input  cpu6_pkg::xlenT       instrE,
   input  cpu6_pkg::xlenT       excpMepc,
   input  logic                 excpMepcEna,
   input  cpu6_pkg::xlenT       readdataM,
   output cpu6_pkg::xlenT       pcnextE,
   output logic                 pcsrcE,
   output cpu6_pkg::xlenT       csrMtvec,
   output cpu6_pkg::xlenT       csrMepc,
   output cpu6_pkg::xlenT       dataaddrM,
   output cpu6_pkg::xlenT       writedataM,
   output logic                 memwriteM
);

   cpu6_pkg::xlenT rd1, rd2;
   cpu6_pkg::xlenT immE;
   cpu6_pkg::xlenT srcB;
   cpu6_pkg::xlenT aluResult;
   cpu6_pkg::xlenT csrRdata;
   cpu6_pkg::xlenT csrWdata;
   cpu6_pkg::xlenT wbData;
   cpu6_pkg::xlenT pcPlus4E;
   logic           equalE;

   cpu6_regfile u_regfile (
      .clk,
      .ra1 (instrE[19:15]),
      .ra2 (instrE[24:20]),
      .wa  (instrE[11:7]),
      .we  (regwriteE),
      .wd  (wbData),
      .rd1,
      .rd2
   );

   always_comb begin
      case (immtypeE)
         cpu6_pkg::ImmS: immE = {{(XLEN-12){instrE[31]}}, instrE[31:25], instrE[11:7]};
         cpu6_pkg::ImmB: immE = {{(XLEN-12){instrE[31]}}, instrE[7], instrE[30:25],
                                 instrE[11:8], 1'b0};
         cpu6_pkg::ImmJ: immE = {{(XLEN-20){instrE[31]}}, instrE[19:12], instrE[20],
                                 instrE[30:21], 1'b0};
         cpu6_pkg::ImmU: immE = {instrE[31:12], 12'b0};
         default:        immE = {{(XLEN-12){instrE[31]}}, instrE[31:20]};
      endcase
   end

   assign srcB = alusrcE ? immE : rd2;

   always_comb begin
      case (alucontrolE)
         cpu6_pkg::AluSub: aluResult = rd1 - srcB;
         cpu6_pkg::AluAnd: aluResult = rd1 & srcB;
         cpu6_pkg::AluOr:  aluResult = rd1 | srcB;
         cpu6_pkg::AluXor: aluResult = rd1 ^ srcB;
         cpu6_pkg::AluSlt: aluResult = XLEN'($signed(rd1) < $signed(srcB));
         cpu6_pkg::AluLui: aluResult = srcB;
         default:          aluResult = rd1 + srcB;
      endcase
   end

   // branch and jal targets share the pc-relative adder
   assign equalE   = (rd1 == rd2);
   assign pcnextE  = pcE + immE;
   assign pcPlus4E = pcE + XLEN'(4);
   assign pcsrcE   = jumpE
                   || ((branchtypeE == cpu6_pkg::BrEq) && equalE)
                   || ((branchtypeE == cpu6_pkg::BrNe) && !equalE);

   assign dataaddrM  = aluResult;
   assign writedataM = rd2;
   assign memwriteM  = memwriteE;

   // immediate forms take the 5-bit rs1 field zero-extended
   assign csrWdata = csrRs1UimmE ? {{(XLEN-5){1'b0}}, instrE[19:15]} : rd1;

   cpu6_csr u_csr (
      .clk,
      .reset,
      .csrAddr  (instrE[31:20]),
      .csrWsc   (csrWscE),
      .csrWdata,
      .excpMepcEna,
      .excpMepc,
      .csrRdata,
      .csrMtvec,
      .csrMepc
   );

   always_comb begin
      if (csrE) begin
         wbData = csrRdata;
      end else if (memtoregE) begin
         wbData = readdataM;
      end else if (jumpE) begin
         wbData = pcPlus4E;
      end else begin
         wbData = aluResult;
      end
   end

endmodule

// File: verilog/cpu6_pipelinereg_idex.sv
module cpu6_pipelinereg_idex (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 flash,
   input  logic                 memtoreg,
   input  logic                 memwrite,
   input  logic                 alusrc,
   input  logic                 regwrite,
   input  logic                 jump,
   input  logic                 csr,
   input  logic                 csrRs1Uimm,
   input  cpu6_pkg::branchTypeT branchtype,
   input  cpu6_pkg::aluCtrlT    alucontrol,
   input  cpu6_pkg::immTypeT    immtype,
   input  cpu6_pkg::csrWscT     csrWsc,
   input  cpu6_pkg::xlenT       pc,
   input  cpu6_pkg::xlenT       instr,
   output logic                 memtoregE,
   output logic                 memwriteE,
   output logic                 alusrcE,
   output logic                 regwriteE,
   output logic                 jumpE,
   output logic                 csrE,
   output logic                 csrRs1UimmE,
   output cpu6_pkg::branchTypeT branchtypeE,
   output cpu6_pkg::aluCtrlT    alucontrolE,
   output cpu6_pkg::immTypeT    immtypeE,
   output cpu6_pkg::csrWscT     csrWscE,
   output cpu6_pkg::xlenT       pcE,
   output cpu6_pkg::xlenT       instrE
);

   // addi x0, x0, 0
   localparam cpu6_pkg::xlenT Nop = 32'h0000_0013;

   always_ff @(posedge clk) begin
      if (reset || flash) begin
         memtoregE   <= 1'b0;
         memwriteE   <= 1'b0;
         alusrcE     <= 1'b0;
         regwriteE   <= 1'b0;
         jumpE       <= 1'b0;
         csrE        <= 1'b0;
         csrRs1UimmE <= 1'b0;
         branchtypeE <= cpu6_pkg::BrNone;
         alucontrolE <= cpu6_pkg::AluAdd;
         immtypeE    <= cpu6_pkg::ImmI;
         csrWscE     <= cpu6_pkg::CsrNone;
         instrE      <= Nop;
      end else begin
         memtoregE   <= memtoreg;
         memwriteE   <= memwrite;
         alusrcE     <= alusrc;
         regwriteE   <= regwrite;
         jumpE       <= jump;
         csrE        <= csr;
         csrRs1UimmE <= csrRs1Uimm;
         branchtypeE <= branchtype;
         alucontrolE <= alucontrol;
         immtypeE    <= immtype;
         csrWscE     <= csrWsc;
         instrE      <= instr;
      end
   end

   // the pc rides along, bubble or not
   always_ff @(posedge clk) begin
      pcE <= pc;
   end

endmodule

// File: verilog/cpu6_excp.sv
module cpu6_excp (
   input  logic           clk,
   input  logic           reset,
   input  cpu6_pkg::xlenT excpPc,
   input  logic           excpIllinstr,
   input  cpu6_pkg::xlenT csrMtvec,
   output logic           excpFlushPcEna,
   output cpu6_pkg::xlenT excpFlushPc,
   output logic           excpMepcEna,
   output cpu6_pkg::xlenT excpMepc
);

   logic trapPending;

   // one capture per trap, the redirect to mtvec is still on its way
   always_ff @(posedge clk) begin
      if (reset) begin
         trapPending <= 1'b0;
      end else begin
         trapPending <= excpIllinstr && !trapPending;
      end
   end

   assign excpFlushPcEna = excpIllinstr;
   assign excpFlushPc    = csrMtvec;

   // by now excpPc holds the address of the offending word
   assign excpMepcEna = trapPending;
   assign excpMepc    = excpPc;

endmodule

// File: verilog/cpu6_controller.sv
module cpu6_controller (
   input  logic [6:0]           op,
   input  logic [2:0]           funct3,
   input  logic [6:0]           funct7,
   output logic                 memtoreg,
   output logic                 memwrite,
   output logic                 alusrc,
   output logic                 regwrite,
   output logic                 jump,
   output logic                 mret,
   output logic                 csr,
   output logic                 csrRs1Uimm,
   output cpu6_pkg::branchTypeT branchtype,
   output cpu6_pkg::aluCtrlT    alucontrol,
   output cpu6_pkg::immTypeT    immtype,
   output cpu6_pkg::csrWscT     csrWsc,
   output logic                 illinstr
);

   always_comb begin
      memtoreg   = 1'b0;
      memwrite   = 1'b0;
      alusrc     = 1'b0;
      regwrite   = 1'b0;
      jump       = 1'b0;
      mret       = 1'b0;
      csr        = 1'b0;
      csrRs1Uimm = 1'b0;
      branchtype = cpu6_pkg::BrNone;
      alucontrol = cpu6_pkg::AluAdd;
      immtype    = cpu6_pkg::ImmI;
      csrWsc     = cpu6_pkg::CsrNone;
      illinstr   = 1'b0;

      case (op)
         cpu6_pkg::OpOp: begin
            regwrite = 1'b1;
            case ({funct7, funct3})
               {7'b0000000, 3'b000}: alucontrol = cpu6_pkg::AluAdd;
               {7'b0100000, 3'b000}: alucontrol = cpu6_pkg::AluSub;
               {7'b0000000, 3'b111}: alucontrol = cpu6_pkg::AluAnd;
               {7'b0000000, 3'b110}: alucontrol = cpu6_pkg::AluOr;
               {7'b0000000, 3'b100}: alucontrol = cpu6_pkg::AluXor;
               {7'b0000000, 3'b010}: alucontrol = cpu6_pkg::AluSlt;
               default:              illinstr   = 1'b1;
            endcase
         end
         cpu6_pkg::OpOpImm: begin
            regwrite = 1'b1;
            alusrc   = 1'b1;
            case (funct3)
               3'b000:  alucontrol = cpu6_pkg::AluAdd;
               3'b111:  alucontrol = cpu6_pkg::AluAnd;
               3'b110:  alucontrol = cpu6_pkg::AluOr;
               3'b100:  alucontrol = cpu6_pkg::AluXor;
               3'b010:  alucontrol = cpu6_pkg::AluSlt;
               default: illinstr   = 1'b1;
            endcase
         end
         cpu6_pkg::OpLoad: begin
            // word access only
            regwrite = 1'b1;
            alusrc   = 1'b1;
            memtoreg = 1'b1;
            illinstr = (funct3 != 3'b010);
         end
         cpu6_pkg::OpStore: begin
            memwrite = 1'b1;
            alusrc   = 1'b1;
            immtype  = cpu6_pkg::ImmS;
            illinstr = (funct3 != 3'b010);
         end
         cpu6_pkg::OpLui: begin
            regwrite   = 1'b1;
            alusrc     = 1'b1;
            alucontrol = cpu6_pkg::AluLui;
            immtype    = cpu6_pkg::ImmU;
         end
         cpu6_pkg::OpBranch: begin
            immtype = cpu6_pkg::ImmB;
            case (funct3)
               3'b000:  branchtype = cpu6_pkg::BrEq;
               3'b001:  branchtype = cpu6_pkg::BrNe;
               default: illinstr   = 1'b1;
            endcase
         end
         cpu6_pkg::OpJal: begin
            jump     = 1'b1;
            regwrite = 1'b1;
            immtype  = cpu6_pkg::ImmJ;
         end
         cpu6_pkg::OpSystem: begin
            case (funct3)
               // funct7 0011000 tells mret apart from ecall and ebreak
               3'b000:  begin
                  mret     = (funct7 == 7'b0011000);
                  illinstr = !mret;
               end
               3'b100:  illinstr = 1'b1;
               default: begin
                  csr        = 1'b1;
                  regwrite   = 1'b1;
                  csrRs1Uimm = funct3[2];
                  case (funct3[1:0])
                     2'b01:   csrWsc = cpu6_pkg::CsrWrite;
                     2'b10:   csrWsc = cpu6_pkg::CsrSet;
                     default: csrWsc = cpu6_pkg::CsrClear;
                  endcase
               end
            endcase
         end
         default: illinstr = 1'b1;
      endcase

      // an illegal word must leave no trace in the machine state
      if (illinstr) begin
         memwrite   = 1'b0;
         regwrite   = 1'b0;
         jump       = 1'b0;
         csr        = 1'b0;
         branchtype = cpu6_pkg::BrNone;
         csrWsc     = cpu6_pkg::CsrNone;
      end
   end

endmodule

// File: verilog/cpu6_csr.sv
module cpu6_csr (
   input  logic             clk,
   input  logic             reset,
   input  logic [11:0]      csrAddr,
   input  cpu6_pkg::csrWscT csrWsc,
   input  cpu6_pkg::xlenT   csrWdata,
   input  logic             excpMepcEna,
   input  cpu6_pkg::xlenT   excpMepc,
   output cpu6_pkg::xlenT   csrRdata,
   output cpu6_pkg::xlenT   csrMtvec,
   output cpu6_pkg::xlenT   csrMepc
);

   cpu6_pkg::xlenT newVal;

   // unknown addresses read as zero
   always_comb begin
      case (csrAddr)
         cpu6_pkg::CsrMtvec: csrRdata = csrMtvec;
         cpu6_pkg::CsrMepc:  csrRdata = csrMepc;
         default:            csrRdata = '0;
      endcase
   end

   always_comb begin
      case (csrWsc)
         cpu6_pkg::CsrWrite: newVal = csrWdata;
         cpu6_pkg::CsrSet:   newVal = csrRdata | csrWdata;
         cpu6_pkg::CsrClear: newVal = csrRdata & ~csrWdata;
         default:            newVal = csrRdata;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         csrMtvec <= '0;
         csrMepc  <= '0;
      end else begin
         if ((csrWsc != cpu6_pkg::CsrNone) && (csrAddr == cpu6_pkg::CsrMtvec)) begin
            csrMtvec <= newVal;
         end
         // trap capture wins over a software write
         if (excpMepcEna) begin
            csrMepc <= excpMepc;
         end else if ((csrWsc != cpu6_pkg::CsrNone) && (csrAddr == cpu6_pkg::CsrMepc)) begin
            csrMepc <= newVal;
         end
      end
   end

endmodule

// File: verilog/cpu6_regfile.sv
module cpu6_regfile (
   input  logic              clk,
   input  cpu6_pkg::regAddrT ra1,
   input  cpu6_pkg::regAddrT ra2,
   input  cpu6_pkg::regAddrT wa,
   input  logic              we,
   input  cpu6_pkg::xlenT    wd,
   output cpu6_pkg::xlenT    rd1,
   output cpu6_pkg::xlenT    rd2
);

   cpu6_pkg::xlenT regs [32];

   always_ff @(posedge clk) begin
      if (we && (wa != '0)) begin
         regs[wa] <= wd;
      end
   end

   // x0 is hardwired, its storage is never read
   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: verilog/cpu6_pkg.sv
package cpu6_pkg;

   localparam int Xlen = 32;

   typedef logic [Xlen-1:0] xlenT;
   typedef logic [4:0]      regAddrT;
   typedef logic [2:0]      aluCtrlT;
   typedef logic [2:0]      immTypeT;
   typedef logic [1:0]      branchTypeT;
   typedef logic [1:0]      csrWscT;

   // ALU operations
   localparam aluCtrlT AluAdd = 3'd0;
   localparam aluCtrlT AluSub = 3'd1;
   localparam aluCtrlT AluAnd = 3'd2;
   localparam aluCtrlT AluOr  = 3'd3;
   localparam aluCtrlT AluXor = 3'd4;
   localparam aluCtrlT AluSlt = 3'd5;
   // passes the immediate straight through
   localparam aluCtrlT AluLui = 3'd6;

   localparam immTypeT ImmI = 3'd0;
   localparam immTypeT ImmS = 3'd1;
   localparam immTypeT ImmB = 3'd2;
   localparam immTypeT ImmJ = 3'd3;
   localparam immTypeT ImmU = 3'd4;

   localparam branchTypeT BrNone = 2'd0;
   localparam branchTypeT BrEq   = 2'd1;
   localparam branchTypeT BrNe   = 2'd2;

   localparam csrWscT CsrNone  = 2'd0;
   localparam csrWscT CsrWrite = 2'd1;
   localparam csrWscT CsrSet   = 2'd2;
   localparam csrWscT CsrClear = 2'd3;

   // RV32I major opcodes
   localparam logic [6:0] OpLoad   = 7'b0000011;
   localparam logic [6:0] OpStore  = 7'b0100011;
   localparam logic [6:0] OpOp     = 7'b0110011;
   localparam logic [6:0] OpOpImm  = 7'b0010011;
   localparam logic [6:0] OpLui    = 7'b0110111;
   localparam logic [6:0] OpBranch = 7'b1100011;
   localparam logic [6:0] OpJal    = 7'b1101111;
   localparam logic [6:0] OpSystem = 7'b1110011;

   localparam int OpcodeHigh = 6;
   localparam int OpcodeLow  = 0;
   localparam int Funct3High = 14;
   localparam int Funct3Low  = 12;
   localparam int Funct7High = 31;
   localparam int Funct7Low  = 25;

   localparam logic [11:0] CsrMtvec = 12'h305;
   localparam logic [11:0] CsrMepc  = 12'h341;

   localparam xlenT ResetPc = '0;

endpackage
